// ==== Makefile ====
# Verilator build of the pooling lane controller testbench

VERILATOR ?= verilator
TOP       ?= pool_lane_ctrl_tb
FILELIST  ?= pool_lane_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TEST OK

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_STR)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/pool_lane_ctrl_tb.sv ====
`timescale 1ns/10ps

module pool_lane_ctrl_tb;

    // ======================================
    // Run shape
    // ======================================

    localparam int FIFO_ADDR_WIDTH = pool_cfg_pkg::DEF_FIFO_ADDR_WIDTH;
    localparam int K_WIDTH         = pool_cfg_pkg::DEF_K_WIDTH;
    localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_WIDTH;
    localparam int CLK_PERIOD      = 4;

    // Windows per phase
    localparam int A_WIN   = 40;
    localparam int B_WIN   = 5;
    localparam int B_EXTRA = 2;
    localparam int B_IDX   = 9;
    localparam int C_WIN   = 8;
    localparam int D_WIN   = 24;
    localparam int E_WIN   = 3;

    // All ofm and index beats of the run
    localparam int TOTAL_BEATS = 5 * A_WIN + 4 * B_WIN + B_EXTRA + B_IDX + 5 * C_WIN
                                 + 2 * D_WIN + 32 * E_WIN;
    localparam int CYCLES_PER_BEAT = 8;
    localparam int MARGIN          = 4;
    localparam int TIMEOUT_NS      = TOTAL_BEATS * CYCLES_PER_BEAT * CLK_PERIOD * MARGIN;

    // ======================================
    // DUT signals
    // ======================================

    logic                     clk;
    logic                     arst_n;
    logic                     flush;
    logic [K_WIDTH-1:0]       cfg_k;
    logic                     idx_valid;
    pool_data_pkg::idx_t      idx;
    logic                     idx_ready;
    logic                     ofm_valid;
    pool_data_pkg::pool_vec_t ofm;
    logic                     ofm_ready;
    logic                     res_valid;
    pool_data_pkg::pool_res_t res;
    logic                     res_ready;

    pool_lane_ctrl #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH),
        .K_WIDTH         (K_WIDTH)
    ) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .cfg_k     (cfg_k),
        .idx_valid (idx_valid),
        .idx       (idx),
        .idx_ready (idx_ready),
        .ofm_valid (ofm_valid),
        .ofm       (ofm),
        .ofm_ready (ofm_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ======================================
    // Model state and bookkeeping
    // ======================================

    integer seed;
    int     stall_left;
    int     vec_errs;
    int     idx_errs;
    int     flag_errs;
    int     other_errs;
    int     full_cycles;

    // Indices held by the FIFO and finished windows not yet paired
    pool_data_pkg::idx_t      idx_q[$];
    pool_data_pkg::pool_vec_t vec_q[$];
    pool_data_pkg::pool_vec_t model_acc;
    pool_data_pkg::pool_vec_t exp_vec;
    pool_data_pkg::idx_t      exp_idx;
    int                       win_cnt;

    logic exp_res_valid;
    logic exp_ofm_ready;
    logic exp_idx_ready;
    // Transfers seen at the last rising edge for the driver
    logic ofm_took;
    logic idx_took;

    // ======================================
    // Compare tasks
    // ======================================

    task automatic check_vec(input string name, input pool_data_pkg::pool_vec_t exp_v,
                             input pool_data_pkg::pool_vec_t act_v);
        if (act_v !== exp_v) begin
            vec_errs++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_idx(input string name, input pool_data_pkg::idx_t exp_v,
                             input pool_data_pkg::idx_t act_v);
        if (act_v !== exp_v) begin
            idx_errs++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            flag_errs++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp_v, act_v);
        end
    endtask

    // ======================================
    // Stimulus helpers
    // ======================================

    // Lane-wise unsigned maximum
    function automatic pool_data_pkg::pool_vec_t fold_max(input pool_data_pkg::pool_vec_t a,
                                                          input pool_data_pkg::pool_vec_t b);
        pool_data_pkg::pool_vec_t m;
        for (int i = 0; i < pool_cfg_pkg::LANES; i++) begin
            m[i] = (a[i] > b[i]) ? a[i] : b[i];
        end
        return m;
    endfunction

    function automatic pool_data_pkg::pool_vec_t rand_vec();
        pool_data_pkg::pool_vec_t v;
        for (int i = 0; i < pool_cfg_pkg::LANES; i++) begin
            v[i] = pool_data_pkg::act_t'($random(seed));
            // Some saturated lanes for the top of the range
            if (($random(seed) & 15) == 0) begin
                v[i] = '1;
            end
        end
        return v;
    endfunction

    // Random res_ready with occasional low bursts
    function automatic logic next_res_ready();
        if (stall_left > 0) begin
            stall_left--;
            return 1'b0;
        end
        if (($random(seed) & 7) == 0) begin
            stall_left = $random(seed) & 7;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // Both input streams at once with the index side faster so the FIFO fills
    task automatic send_streams(input int n_ofm, input int n_idx);
        int ofm_left;
        int idx_left;
        ofm_left = n_ofm;
        idx_left = n_idx;
        while (ofm_left > 0 || idx_left > 0 || ofm_valid || idx_valid) begin
            @(negedge clk);
            if (ofm_valid && ofm_took) begin
                ofm_valid = 1'b0;
            end
            if (idx_valid && idx_took) begin
                idx_valid = 1'b0;
            end
            if (!ofm_valid && ofm_left > 0 && ($random(seed) & 1) != 0) begin
                ofm       = rand_vec();
                ofm_valid = 1'b1;
                ofm_left--;
            end
            if (!idx_valid && idx_left > 0 && ($random(seed) & 7) != 0) begin
                idx       = pool_data_pkg::idx_t'($random(seed));
                idx_valid = 1'b1;
                idx_left--;
            end
            res_ready = next_res_ready();
        end
    endtask

    task automatic drain_results();
        while (vec_q.size() != 0 || idx_q.size() != 0) begin
            @(negedge clk);
            res_ready = next_res_ready();
        end
    endtask

    // Result side held off so nothing pops during the flush
    task automatic pulse_flush(input logic [K_WIDTH-1:0] new_k);
        @(negedge clk);
        flush     = 1'b1;
        res_ready = 1'b0;
        cfg_k     = new_k;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // ======================================
    // Reference model sampled at the rising edge
    // ======================================

    always @(posedge clk) begin
        if (arst_n) begin
            // Per-cycle res_valid check also pins the one-cycle latency
            exp_res_valid = (vec_q.size() > 0) && (idx_q.size() > 0);
            exp_ofm_ready = (vec_q.size() == 0) || (exp_res_valid && res_ready);
            exp_idx_ready = (idx_q.size() < FIFO_DEPTH);
            check_flag("res_valid", exp_res_valid, res_valid);
            check_flag("ofm_ready", exp_ofm_ready, ofm_ready);
            check_flag("idx_ready", exp_idx_ready, idx_ready);
            if (!idx_ready) begin
                full_cycles++;
            end
            ofm_took = ofm_valid && ofm_ready;
            idx_took = idx_valid && idx_ready;
            if (flush) begin
                idx_q.delete();
                vec_q.delete();
                win_cnt = 0;
            end else begin
                // Pairing before new windows since the slot may refill this edge
                if (res_valid && res_ready) begin
                    if (vec_q.size() == 0 || idx_q.size() == 0) begin
                        other_errs++;
                        $display("Result beat at %0t with no pending window or index", $time);
                    end else begin
                        exp_vec = vec_q.pop_front();
                        exp_idx = idx_q.pop_front();
                        check_vec("res.vec", exp_vec, res.vec);
                        check_idx("res.addr", exp_idx, res.addr);
                    end
                end
                if (ofm_took) begin
                    model_acc = (win_cnt == 0) ? ofm : fold_max(model_acc, ofm);
                    win_cnt++;
                    if (win_cnt == int'(cfg_k)) begin
                        vec_q.push_back(model_acc);
                        win_cnt = 0;
                    end
                end
                if (idx_took) begin
                    idx_q.push_back(idx);
                end
            end
        end else begin
            ofm_took = 1'b0;
            idx_took = 1'b0;
        end
    end

    // ======================================
    // Watchdog
    // ======================================

    initial begin
        #(TIMEOUT_NS);
        other_errs++;
        $display("Timeout: run did not complete within %0d ns", TIMEOUT_NS);
        $display("Errors: vec=%0d idx=%0d flag=%0d other=%0d",
                 vec_errs, idx_errs, flag_errs, other_errs);
        $display("TEST FAILED");
        $finish;
    end

    // ======================================
    // Main sequence
    // ======================================

    initial begin
        seed        = 32'hea4d;
        stall_left  = 0;
        vec_errs    = 0;
        idx_errs    = 0;
        flag_errs   = 0;
        other_errs  = 0;
        full_cycles = 0;
        win_cnt     = 0;
        ofm_took    = 1'b0;
        idx_took    = 1'b0;
        clk         = 1'b0;
        arst_n      = 1'b0;
        flush       = 1'b0;
        cfg_k       = K_WIDTH'(4);
        idx_valid   = 1'b0;
        idx         = '0;
        ofm_valid   = 1'b0;
        ofm         = '0;
        res_ready   = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Window of 4 with back-pressure so the FIFO runs full
        send_streams(4 * A_WIN, A_WIN);
        drain_results();

        // Partial window and spare indices before a flush
        send_streams(4 * B_WIN + B_EXTRA, B_IDX);
        pulse_flush(K_WIDTH'(4));

        // Clean restart after the flush
        send_streams(4 * C_WIN, C_WIN);
        drain_results();

        // Pass-through windows
        pulse_flush(K_WIDTH'(1));
        send_streams(D_WIN, D_WIN);
        drain_results();

        // Largest window
        pulse_flush(K_WIDTH'(31));
        send_streams(31 * E_WIN, E_WIN);
        drain_results();

        repeat (4) @(negedge clk);
        if (full_cycles == 0) begin
            other_errs++;
            $display("Index FIFO never ran full so the full case went unchecked");
        end
        $display("Index FIFO was full for %0d cycles", full_cycles);
        $display("Errors: vec=%0d idx=%0d flag=%0d other=%0d",
                 vec_errs, idx_errs, flag_errs, other_errs);
        if (vec_errs + idx_errs + flag_errs + other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== pool_lane_ctrl.f ====
verilog/pool_cfg_pkg.sv
verilog/pool_data_pkg.sv
verilog/pool_idx_fifo.sv
verilog/pool_max_core.sv
verilog/pool_out_join.sv
verilog/pool_lane_ctrl.sv
dv/pool_lane_ctrl_tb.sv

// ==== verilog/pool_cfg_pkg.sv ====
package pool_cfg_pkg;

    // ======================================
    // Datapath shape
    // ======================================

    // Parallel activation lanes, one word of bytes
    localparam int LANES = 64;

    // Bits per unsigned activation
    localparam int ACT_WIDTH = 8;

    // Bits per destination index from the pooling engine
    localparam int IDX_WIDTH = 10;

    // ======================================
    // Default depths
    // ======================================

    // Index FIFO address width, 32 entries
    localparam int DEF_FIFO_ADDR_WIDTH = 5;

    // Window counter width, cfg_k up to 31
    localparam int DEF_K_WIDTH = 5;

    // Full vector width, handy for checks
    localparam int VEC_WIDTH = LANES * ACT_WIDTH;

endpackage

// ==== verilog/pool_data_pkg.sv ====
package pool_data_pkg;

    // ======================================
    // Activation data
    // ======================================

    // Single unsigned activation
    typedef logic [pool_cfg_pkg::ACT_WIDTH-1:0] act_t;

    // One output feature map vector
    // Lane 0 sits in the low byte
    typedef act_t [pool_cfg_pkg::LANES-1:0] pool_vec_t;

    // ======================================
    // Index data
    // ======================================

    // Destination index of one pooled window
    typedef logic [pool_cfg_pkg::IDX_WIDTH-1:0] idx_t;

    // ======================================
    // Result beat
    // ======================================

    // Index in the upper bits, pooled vector below
    typedef struct packed {
        idx_t      addr;
        pool_vec_t vec;
    } pool_res_t;

    // Result width for quick reference
    localparam int RES_WIDTH = pool_cfg_pkg::IDX_WIDTH + pool_cfg_pkg::VEC_WIDTH;

endpackage

// ==== verilog/pool_idx_fifo.sv ====
`timescale 1ns/10ps

module pool_idx_fifo #(
    parameter int FIFO_ADDR_WIDTH = pool_cfg_pkg::DEF_FIFO_ADDR_WIDTH
) (
    input  logic                clk,
    input  logic                arst_n,

    // Synchronous clear of all entries
    input  logic                flush,

    // Write side
    input  logic                push_valid,
    input  pool_data_pkg::idx_t push_data,
    output logic                push_ready,

    // Read side, head always shows the oldest entry
    input  logic                pop,
    output logic                head_valid,
    output pool_data_pkg::idx_t head
);

    // ======================================
    // Storage and pointers
    // ======================================

    localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

    pool_data_pkg::idx_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic push_xfer;
    logic pop_xfer;

    // Same slot, different lap means full
    assign full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                   (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign push_ready = !full;
    assign push_xfer  = push_valid && push_ready;
    assign pop_xfer   = pop && !empty;

    // First word fall through
    assign head_valid = !empty;
    assign head       = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];

    // ======================================
    // Pointer update
    // ======================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            // Index taken in the flush cycle goes too
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_xfer) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_xfer) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Entry array, written on accepted push only
    always_ff @(posedge clk) begin
        if (push_xfer) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= push_data;
        end
    end

    // ======================================
    // Checks
    // ======================================

    // Join must not pop a missing index
    pop_not_empty_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> !empty
    ) else $error("pool_idx_fifo: pop while empty");

    // Flush and pop in one cycle would lose a pairing
    flush_no_pop_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(flush && pop)
    ) else $error("pool_idx_fifo: flush and pop together");

endmodule

// ==== verilog/pool_lane_ctrl.sv ====
`timescale 1ns/10ps

module pool_lane_ctrl #(
    parameter int FIFO_ADDR_WIDTH = pool_cfg_pkg::DEF_FIFO_ADDR_WIDTH,
    parameter int K_WIDTH         = pool_cfg_pkg::DEF_K_WIDTH
) (
    input  logic                     clk,
    input  logic                     arst_n,

    // Control
    input  logic                     flush,
    // Window size, held between flushes
    input  logic [K_WIDTH-1:0]       cfg_k,

    // Destination indices from the pooling engine
    input  logic                     idx_valid,
    input  pool_data_pkg::idx_t      idx,
    output logic                     idx_ready,

    // Output feature map vectors
    input  logic                     ofm_valid,
    input  pool_data_pkg::pool_vec_t ofm,
    output logic                     ofm_ready,

    // Pooled vector with its index
    output logic                     res_valid,
    output pool_data_pkg::pool_res_t res,
    input  logic                     res_ready
);

    // ======================================
    // Internal links
    // ======================================

    // Index FIFO head towards the join
    logic                     head_valid;
    pool_data_pkg::idx_t      head;
    logic                     pop;

    // Window result towards the join
    logic                     max_valid;
    pool_data_pkg::pool_vec_t max_vec;
    logic                     max_ready;

    // ======================================
    // Index buffer
    // ======================================

    pool_idx_fifo #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) idx_fifo_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .push_valid (idx_valid),
        .push_data  (idx),
        .push_ready (idx_ready),
        .pop        (pop),
        .head_valid (head_valid),
        .head       (head)
    );

    // ======================================
    // Max pooling
    // ======================================

    pool_max_core #(
        .K_WIDTH (K_WIDTH)
    ) max_core_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .cfg_k     (cfg_k),
        .in_valid  (ofm_valid),
        .in_vec    (ofm),
        .in_ready  (ofm_ready),
        .out_valid (max_valid),
        .out_vec   (max_vec),
        .out_ready (max_ready)
    );

    // ======================================
    // Result pairing
    // ======================================

    // No register here, result follows the sources
    pool_out_join join_i (
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .max_valid  (max_valid),
        .max_vec    (max_vec),
        .max_ready  (max_ready),
        .res_valid  (res_valid),
        .res        (res),
        .res_ready  (res_ready)
    );

endmodule

// ==== verilog/pool_max_core.sv ====
`timescale 1ns/10ps

module pool_max_core #(
    parameter int K_WIDTH = pool_cfg_pkg::DEF_K_WIDTH
) (
    input  logic                     clk,
    input  logic                     arst_n,

    // Control
    input  logic                     flush,
    input  logic [K_WIDTH-1:0]       cfg_k,

    // Incoming activation vectors
    input  logic                     in_valid,
    input  pool_data_pkg::pool_vec_t in_vec,
    output logic                     in_ready,

    // Finished window maximum
    output logic                     out_valid,
    output pool_data_pkg::pool_vec_t out_vec,
    input  logic                     out_ready
);

    // ======================================
    // Window bookkeeping
    // ======================================

    // Beats already folded into the current window
    logic [K_WIDTH-1:0] win_cnt;
    logic [K_WIDTH-1:0] win_last;

    logic in_xfer;
    logic first_beat;
    logic last_beat;

    // Running maximum of the open window
    pool_data_pkg::pool_vec_t acc;
    // Lane-wise max of acc and the new beat
    pool_data_pkg::pool_vec_t lane_max;
    // What the window holds after this beat
    pool_data_pkg::pool_vec_t next_acc;

    assign win_last = cfg_k - 1'b1;

    // Stall only when the result slot stays occupied
    assign in_ready = !out_valid || out_ready;
    assign in_xfer  = in_valid && in_ready;

    assign first_beat = (win_cnt == '0);
    assign last_beat  = (win_cnt == win_last);

    // ======================================
    // Lane comparators
    // ======================================

    // All lanes in parallel, unsigned compare
    always_comb begin
        for (int i = 0; i < pool_cfg_pkg::LANES; i++) begin
            lane_max[i] = (acc[i] > in_vec[i]) ? acc[i] : in_vec[i];
        end
    end

    // First beat loads, later beats reduce
    assign next_acc = first_beat ? in_vec : lane_max;

    // ======================================
    // Control state
    // ======================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            win_cnt   <= '0;
            out_valid <= 1'b0;
        end else if (flush) begin
            // Partial window and pending result dropped
            win_cnt   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_xfer) begin
                // Wrap after the cfg_k-th beat
                win_cnt <= last_beat ? '0 : win_cnt + 1'b1;
            end
            if (in_xfer && last_beat) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // ======================================
    // Accumulator and result slot
    // ======================================

    always_ff @(posedge clk) begin
        if (flush) begin
            acc <= '0;
        end else if (in_xfer) begin
            acc <= next_acc;
        end
        // Result moves out while the next window opens
        if (!flush && in_xfer && last_beat) begin
            out_vec <= next_acc;
        end
    end

    // ======================================
    // Checks
    // ======================================

    // Zero window size would never close a window
    cfg_k_nonzero_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        cfg_k != '0
    ) else $error("pool_max_core: cfg_k is zero");

    // Held result must not change under back-pressure
    out_stable_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> $stable(out_vec)
    ) else $error("pool_max_core: out_vec changed while stalled");

endmodule

// ==== verilog/pool_out_join.sv ====
`timescale 1ns/10ps

module pool_out_join (
    // Oldest buffered index
    input  logic                     head_valid,
    input  pool_data_pkg::idx_t      head,
    output logic                     pop,

    // Pooled vector from the max core
    input  logic                     max_valid,
    input  pool_data_pkg::pool_vec_t max_vec,
    output logic                     max_ready,

    // Paired result beat
    output logic                     res_valid,
    output pool_data_pkg::pool_res_t res,
    input  logic                     res_ready
);

    // ======================================
    // Pairing
    // ======================================

    logic res_xfer;

    // Both halves needed before a beat goes out
    assign res_valid = head_valid && max_valid;
    assign res_xfer  = res_valid && res_ready;

    // Both sources release on the same transfer
    // Keeps index and window in lock step
    assign pop       = res_xfer;
    assign max_ready = res_xfer;

    // Result fields straight from the sources
    assign res.addr = head;
    assign res.vec  = max_vec;

    // ======================================
    // Checks
    // ======================================

    // Pops stay paired and only consume present data
    always_comb begin
        pair_lock_a: assert final (
            (pop == max_ready) && (!pop || (head_valid && max_valid))
        ) else $error("pool_out_join: pairing slipped");
    end

endmodule
